// File: source/neo_pkg.sv
`default_nettype none

package neo_pkg;

	// Regions of a .neo file, in load order
	typedef enum logic [2:0] {
		RGN_P    = 3'd0,
		RGN_S    = 3'd1,
		RGN_M    = 3'd2,
		RGN_V1   = 3'd3,
		RGN_V2   = 3'd4,
		RGN_C    = 3'd5,
		RGN_DONE = 3'd6
	} neo_region_e;

	// Header layout
	localparam logic [12:0] HDR_BYTES      = 13'd4096;
	localparam logic [12:0] HDR_SIZE_FIRST = 13'd4;
	localparam logic [12:0] HDR_SIZE_LAST  = 13'd27;

	localparam int SIZE_W    = 32;
	localparam int OFFSET_W  = 26;
	localparam int DL_ADDR_W = 27;
	localparam int P1_ADDR_W = 24;
	localparam int P2_ADDR_W = 26;

	// Bank 3 prefixes above the offset bits
	localparam logic [4:0] FIX_PREFIX  = 5'b11100;
	localparam logic [4:0] MROM_PREFIX = 5'b11110;

	// P size sits at the bottom, bytes shift in from the top
	typedef struct packed {
		logic [SIZE_W-1:0] c;
		logic [SIZE_W-1:0] v2;
		logic [SIZE_W-1:0] v1;
		logic [SIZE_W-1:0] m;
		logic [SIZE_W-1:0] s;
		logic [SIZE_W-1:0] p;
	} region_sizes_t;

	typedef struct packed {
		logic [DL_ADDR_W-1:0] addr;
		logic [7:0]           data;
	} dl_byte_t;

	typedef struct packed {
		logic [P1_ADDR_W-2:0] addr;
		logic [1:0]           ds;
		logic [15:0]          data;
	} p1_req_t;

	typedef struct packed {
		logic [P2_ADDR_W-2:0] addr;
		logic [1:0]           ds;
		logic [15:0]          data;
	} p2_req_t;

endpackage

`default_nettype wire

// File: source/neo_header_parser.sv
`timescale 1ns/10ps
`default_nettype none

module neo_header_parser (
	input  wire logic              CLK_48M,
	input  wire logic              rst,
	input  wire neo_pkg::dl_byte_t dl_byte,
	input  wire logic              dl_fire,
	output neo_pkg::region_sizes_t sizes,
	output logic                   hdr_done
);

	logic is_size;
	logic is_last;

	assign is_size = (dl_byte.addr >= neo_pkg::HDR_SIZE_FIRST) &&
		(dl_byte.addr <= neo_pkg::HDR_SIZE_LAST);
	assign is_last = dl_byte.addr == neo_pkg::HDR_BYTES - 1;

	// Six little-endian 32-bit fields with the first byte ending up at p[7:0]
	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			sizes <= '0;
		end else if (dl_fire && is_size) begin
			sizes <= {dl_byte.data, sizes[$bits(neo_pkg::region_sizes_t)-1:8]};
		end
	end

	// Pulses in the cycle the last header byte is taken
	assign hdr_done = dl_fire && is_last;

endmodule

`default_nettype wire

// File: source/neo_region_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module neo_region_ctrl (
	input  wire logic                      CLK_48M,
	input  wire logic                      rst,
	input  wire neo_pkg::dl_byte_t         dl_byte,
	input  wire logic                      dl_valid,
	output logic                           dl_ready,
	output logic                           dl_fire,
	input  wire neo_pkg::region_sizes_t    sizes,
	input  wire logic                      hdr_done,
	output neo_pkg::neo_region_e           region,
	output logic [neo_pkg::OFFSET_W-1:0]   offset,
	output logic                           p1_push,
	input  wire logic                      p1_can_accept,
	output logic                           p2_push,
	input  wire logic                      p2_can_accept,
	output logic                           load_done
);

	typedef enum logic {
		ST_ACCEPT,
		ST_STEP
	} state_e;

	state_e                        state;
	logic                          started;
	logic                          is_hdr;
	logic                          to_port1;
	logic                          port_ok;
	logic [neo_pkg::OFFSET_W-1:0]  offset_inc;
	logic [neo_pkg::OFFSET_W-1:0]  cur_size;
	logic [neo_pkg::OFFSET_W-1:0]  next_size;
	neo_pkg::neo_region_e          next_region;

	function automatic logic [neo_pkg::OFFSET_W-1:0] size_of(
		input neo_pkg::neo_region_e r,
		input neo_pkg::region_sizes_t s
	);
		case (r)
			neo_pkg::RGN_P:  size_of = s.p[neo_pkg::OFFSET_W-1:0];
			neo_pkg::RGN_S:  size_of = s.s[neo_pkg::OFFSET_W-1:0];
			neo_pkg::RGN_M:  size_of = s.m[neo_pkg::OFFSET_W-1:0];
			neo_pkg::RGN_V1: size_of = s.v1[neo_pkg::OFFSET_W-1:0];
			neo_pkg::RGN_V2: size_of = s.v2[neo_pkg::OFFSET_W-1:0];
			neo_pkg::RGN_C:  size_of = s.c[neo_pkg::OFFSET_W-1:0];
			default:         size_of = '0;
		endcase
	endfunction

	assign next_region = neo_pkg::neo_region_e'(region + 3'd1);
	assign cur_size    = size_of(region, sizes);
	assign next_size   = size_of(next_region, sizes);
	assign offset_inc  = offset + 1'b1;

	assign is_hdr   = dl_byte.addr < neo_pkg::HDR_BYTES;
	assign to_port1 = region inside {neo_pkg::RGN_P, neo_pkg::RGN_S, neo_pkg::RGN_M};
	// DONE drops bytes, so it never waits on a port
	assign port_ok  = (region == neo_pkg::RGN_DONE) ||
		(to_port1 ? p1_can_accept : p2_can_accept);

	assign dl_ready = started && (state == ST_ACCEPT) && (is_hdr || port_ok);
	assign dl_fire  = dl_valid && dl_ready;

	assign p1_push = dl_fire && !is_hdr && to_port1;
	assign p2_push = dl_fire && !is_hdr && !to_port1 && (region != neo_pkg::RGN_DONE);

	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			state     <= ST_ACCEPT;
			started   <= 1'b0;
			region    <= neo_pkg::RGN_P;
			offset    <= '0;
			load_done <= 1'b0;
		end else begin
			started <= 1'b1;
			case (state)
				ST_ACCEPT: begin
					if (dl_fire && is_hdr) begin
						// Any header byte restarts the walk
						region    <= neo_pkg::RGN_P;
						offset    <= '0;
						load_done <= 1'b0;
						if (hdr_done)
							state <= ST_STEP;
					end else if (p1_push || p2_push) begin
						offset <= offset_inc;
						if (offset_inc == cur_size)
							state <= ST_STEP;
					end
				end
				ST_STEP: begin
					if (offset == cur_size) begin
						region <= next_region;
						offset <= '0;
						if (next_region == neo_pkg::RGN_DONE) begin
							state     <= ST_ACCEPT;
							load_done <= 1'b1;
						end else if (next_size != '0) begin
							state <= ST_ACCEPT;
						end
					end else begin
						state <= ST_ACCEPT;
					end
				end
				default: state <= ST_ACCEPT;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/neo_addr_map.sv
`timescale 1ns/10ps
`default_nettype none

module neo_addr_map (
	input  wire neo_pkg::neo_region_e           region,
	input  wire logic [neo_pkg::OFFSET_W-1:0]   offset,
	input  wire neo_pkg::dl_byte_t              dl_byte,
	input  wire neo_pkg::region_sizes_t         sizes,
	output neo_pkg::p1_req_t                    p1_req,
	output neo_pkg::p2_req_t                    p2_req
);

	logic [neo_pkg::P1_ADDR_W-1:0] p1_addr;
	logic [neo_pkg::P2_ADDR_W-1:0] p2_addr;
	logic [neo_pkg::P2_ADDR_W-1:0] c_size;
	logic [neo_pkg::P2_ADDR_W-1:0] v1_size;
	logic [neo_pkg::DL_ADDR_W-1:0] a;

	assign c_size  = sizes.c[neo_pkg::P2_ADDR_W-1:0];
	assign v1_size = sizes.v1[neo_pkg::P2_ADDR_W-1:0];
	assign a       = dl_byte.addr;

	// Bank 3 placement
	always_comb begin
		case (region)
			neo_pkg::RGN_S:
				p1_addr = {neo_pkg::FIX_PREFIX, offset[18:5], offset[2:0], ~offset[4], offset[3]};
			neo_pkg::RGN_M:
				p1_addr = {neo_pkg::MROM_PREFIX, offset[18:0]};
			default:
				p1_addr = offset[neo_pkg::P1_ADDR_W-1:0];
		endcase
	end

	// Banks 0-2, C first, then V1 and V2 stacked on top
	always_comb begin
		case (region)
			neo_pkg::RGN_V1:
				p2_addr = c_size + offset;
			neo_pkg::RGN_V2:
				p2_addr = c_size + v1_size + offset;
			default:
				p2_addr = {offset[25:7], a[5:2], ~a[6], a[0], a[1]};
		endcase
	end

	// Odd byte goes on the high lane
	always_comb begin
		p1_req.addr = p1_addr[neo_pkg::P1_ADDR_W-1:1];
		p1_req.ds   = {p1_addr[0], ~p1_addr[0]};
		p1_req.data = {dl_byte.data, dl_byte.data};
		p2_req.addr = p2_addr[neo_pkg::P2_ADDR_W-1:1];
		p2_req.ds   = {p2_addr[0], ~p2_addr[0]};
		p2_req.data = {dl_byte.data, dl_byte.data};
	end

endmodule

`default_nettype wire

// File: source/neo_write_port.sv
`timescale 1ns/10ps
`default_nettype none

module neo_write_port #(
	parameter type req_t = logic [15:0]
) (
	input  wire logic CLK_48M,
	input  wire logic rst,
	input  wire logic push,
	input  wire req_t push_req,
	output logic      can_accept,
	output req_t      req,
	output logic      valid,
	input  wire logic ready
);

	// Room now, or the held item leaves on this edge
	assign can_accept = !valid || ready;

	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			valid <= 1'b0;
		end else if (push) begin
			valid <= 1'b1;
		end else if (ready) begin
			valid <= 1'b0;
		end
	end

	always_ff @(posedge CLK_48M) begin
		if (push)
			req <= push_req;
	end

endmodule

`default_nettype wire

// File: source/neo_cart_loader.sv
`timescale 1ns/10ps
`default_nettype none

module neo_cart_loader (
	input  wire logic              CLK_48M,
	input  wire logic              rst,
	input  wire neo_pkg::dl_byte_t dl_byte,
	input  wire logic              dl_valid,
	output logic                   dl_ready,
	output neo_pkg::p1_req_t       p1_req,
	output logic                   p1_valid,
	input  wire logic              p1_ready,
	output neo_pkg::p2_req_t       p2_req,
	output logic                   p2_valid,
	input  wire logic              p2_ready,
	output logic                   load_done
);

	logic                          dl_fire;
	logic                          hdr_done;
	neo_pkg::region_sizes_t        sizes;
	neo_pkg::neo_region_e          region;
	logic [neo_pkg::OFFSET_W-1:0]  offset;
	logic                          p1_push;
	logic                          p2_push;
	logic                          p1_can_accept;
	logic                          p2_can_accept;
	neo_pkg::p1_req_t              p1_next;
	neo_pkg::p2_req_t              p2_next;

	neo_header_parser u_parser (
		.CLK_48M  (CLK_48M),
		.rst      (rst),
		.dl_byte  (dl_byte),
		.dl_fire  (dl_fire),
		.sizes    (sizes),
		.hdr_done (hdr_done)
	);

	neo_region_ctrl u_ctrl (
		.CLK_48M       (CLK_48M),
		.rst           (rst),
		.dl_byte       (dl_byte),
		.dl_valid      (dl_valid),
		.dl_ready      (dl_ready),
		.dl_fire       (dl_fire),
		.sizes         (sizes),
		.hdr_done      (hdr_done),
		.region        (region),
		.offset        (offset),
		.p1_push       (p1_push),
		.p1_can_accept (p1_can_accept),
		.p2_push       (p2_push),
		.p2_can_accept (p2_can_accept),
		.load_done     (load_done)
	);

	neo_addr_map u_map (
		.region  (region),
		.offset  (offset),
		.dl_byte (dl_byte),
		.sizes   (sizes),
		.p1_req  (p1_next),
		.p2_req  (p2_next)
	);

	// Bank 3 writes
	neo_write_port #(.req_t(neo_pkg::p1_req_t)) u_port1 (
		.CLK_48M    (CLK_48M),
		.rst        (rst),
		.push       (p1_push),
		.push_req   (p1_next),
		.can_accept (p1_can_accept),
		.req        (p1_req),
		.valid      (p1_valid),
		.ready      (p1_ready)
	);

	// Bank 0-2 writes
	neo_write_port #(.req_t(neo_pkg::p2_req_t)) u_port2 (
		.CLK_48M    (CLK_48M),
		.rst        (rst),
		.push       (p2_push),
		.push_req   (p2_next),
		.can_accept (p2_can_accept),
		.req        (p2_req),
		.valid      (p2_valid),
		.ready      (p2_ready)
	);

endmodule

`default_nettype wire

// File: verif/neo_cart_loader_chk.sv
`timescale 1ns/10ps
`default_nettype none

module neo_cart_loader_chk (
	input wire logic             CLK_48M,
	input wire logic             rst,
	input wire neo_pkg::p1_req_t p1_req,
	input wire logic             p1_valid,
	input wire logic             p1_ready,
	input wire neo_pkg::p2_req_t p2_req,
	input wire logic             p2_valid,
	input wire logic             p2_ready
);

	int unsigned fails = 0;

	// A stalled request holds its payload
	p1_hold: assert property (@(posedge CLK_48M) disable iff (rst)
		p1_valid && !p1_ready |=> $stable(p1_req))
		else begin
			$error("p1_req changed while p1_valid was high and p1_ready low");
			fails++;
		end

	p2_hold: assert property (@(posedge CLK_48M) disable iff (rst)
		p2_valid && !p2_ready |=> $stable(p2_req))
		else begin
			$error("p2_req changed while p2_valid was high and p2_ready low");
			fails++;
		end

	// Both ports leave reset empty
	reset_idle: assert property (@(posedge CLK_48M)
		rst |=> !p1_valid && !p2_valid)
		else begin
			$error("write port valid high in the cycle after reset");
			fails++;
		end

endmodule

bind neo_cart_loader neo_cart_loader_chk u_chk (
	.CLK_48M  (CLK_48M),
	.rst      (rst),
	.p1_req   (p1_req),
	.p1_valid (p1_valid),
	.p1_ready (p1_ready),
	.p2_req   (p2_req),
	.p2_valid (p2_valid),
	.p2_ready (p2_ready)
);

`default_nettype wire

// File: verif/tb_neo_cart_loader.sv
`timescale 1ns/10ps
`default_nettype none

module tb_neo_cart_loader;

	localparam int HDR_LEN    = 4096;
	localparam int WAIT_LIMIT = 2000;

	logic              CLK_48M;
	logic              rst;
	neo_pkg::dl_byte_t dl_byte;
	logic              dl_valid;
	logic              dl_ready;
	neo_pkg::p1_req_t  p1_req;
	logic              p1_valid;
	logic              p1_ready;
	neo_pkg::p2_req_t  p2_req;
	logic              p2_valid;
	logic              p2_ready;
	logic              load_done;

	integer           seed;
	integer           rdy_seed;
	int               sz[6];
	int               ready_pct;
	int               exp_n1;
	int               exp_n2;
	int               n_p1;
	int               n_p2;
	int               errors;
	int               tests;
	bit               aborted;
	logic [7:0]       rom_q[$];
	neo_pkg::p1_req_t exp_p1_q[$];
	neo_pkg::p2_req_t exp_p2_q[$];

	neo_cart_loader u_dut (
		.CLK_48M   (CLK_48M),
		.rst       (rst),
		.dl_byte   (dl_byte),
		.dl_valid  (dl_valid),
		.dl_ready  (dl_ready),
		.p1_req    (p1_req),
		.p1_valid  (p1_valid),
		.p1_ready  (p1_ready),
		.p2_req    (p2_req),
		.p2_valid  (p2_valid),
		.p2_ready  (p2_ready),
		.load_done (load_done)
	);

	always #20 CLK_48M = ~CLK_48M;

	// SDRAM side accepts with the chance given per test
	always @(posedge CLK_48M) begin
		p1_ready <= ({$random(rdy_seed)} % 100) < ready_pct;
		p2_ready <= ({$random(rdy_seed)} % 100) < ready_pct;
	end

	function automatic neo_pkg::p1_req_t p1_expect(input int rgn, input int off,
		input logic [7:0] d);
		logic [25:0]      o;
		logic [23:0]      ba;
		neo_pkg::p1_req_t r;
		o = off[25:0];
		case (rgn)
			1:       ba = {neo_pkg::FIX_PREFIX, o[18:5], o[2:0], ~o[4], o[3]};
			2:       ba = {neo_pkg::MROM_PREFIX, o[18:0]};
			default: ba = o[23:0];
		endcase
		r.addr = ba[23:1];
		r.ds   = {ba[0], ~ba[0]};
		r.data = {d, d};
		return r;
	endfunction

	function automatic neo_pkg::p2_req_t p2_expect(input int rgn, input int off,
		input logic [26:0] a, input logic [7:0] d);
		logic [25:0]      o;
		logic [25:0]      ba;
		neo_pkg::p2_req_t r;
		o = off[25:0];
		case (rgn)
			3:       ba = 26'(sz[5] + off);
			4:       ba = 26'(sz[5] + sz[3] + off);
			default: ba = {o[25:7], a[5:2], ~a[6], a[0], a[1]};
		endcase
		r.addr = ba[25:1];
		r.ds   = {ba[0], ~ba[0]};
		r.data = {d, d};
		return r;
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] exp,
		input logic [63:0] got);
		$display("ERR %s expected %h got %h", name, exp, got);
		errors++;
	endtask

	task automatic check_p1(input neo_pkg::p1_req_t got);
		neo_pkg::p1_req_t exp;
		n_p1++;
		if (exp_p1_q.size() == 0) begin
			$display("Port 1 wrote word %h while no write was expected", got.addr);
			errors++;
			return;
		end
		exp = exp_p1_q.pop_front();
		if (got.addr !== exp.addr)
			report_mismatch("p1_req.addr", exp.addr, got.addr);
		if (got.ds !== exp.ds)
			report_mismatch("p1_req.ds", exp.ds, got.ds);
		if (got.data !== exp.data)
			report_mismatch("p1_req.data", exp.data, got.data);
	endtask

	task automatic check_p2(input neo_pkg::p2_req_t got);
		neo_pkg::p2_req_t exp;
		n_p2++;
		if (exp_p2_q.size() == 0) begin
			$display("Port 2 wrote word %h while no write was expected", got.addr);
			errors++;
			return;
		end
		exp = exp_p2_q.pop_front();
		if (got.addr !== exp.addr)
			report_mismatch("p2_req.addr", exp.addr, got.addr);
		if (got.ds !== exp.ds)
			report_mismatch("p2_req.ds", exp.ds, got.ds);
		if (got.data !== exp.data)
			report_mismatch("p2_req.data", exp.data, got.data);
	endtask

	// Transfers happen on the next rising edge
	always @(negedge CLK_48M) begin
		if (!rst && p1_valid && p1_ready)
			check_p1(p1_req);
		if (!rst && p2_valid && p2_ready)
			check_p2(p2_req);
	end

	task automatic send_byte(input logic [26:0] addr, input logic [7:0] data);
		int waited;
		if (aborted)
			return;
		dl_byte  <= '{addr: addr, data: data};
		dl_valid <= 1'b1;
		waited = 0;
		do begin
			@(negedge CLK_48M);
			waited++;
		end while (!dl_ready && waited < WAIT_LIMIT);
		if (!dl_ready) begin
			$display("Timeout, dl_ready stayed low for the byte at address %h", addr);
			aborted = 1;
		end
		@(posedge CLK_48M);
	endtask

	task automatic wait_load_done();
		int waited;
		waited = 0;
		do begin
			@(negedge CLK_48M);
			waited++;
		end while (!load_done && waited < WAIT_LIMIT && !aborted);
		if (!load_done && !aborted) begin
			$display("Timeout, load_done never rose after the last ROM byte");
			aborted = 1;
		end
		@(posedge CLK_48M);
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		do begin
			@(negedge CLK_48M);
			waited++;
		end while ((exp_p1_q.size() != 0 || exp_p2_q.size() != 0 || p1_valid || p2_valid)
			&& waited < WAIT_LIMIT && !aborted);
		if (exp_p1_q.size() != 0 || exp_p2_q.size() != 0 || p1_valid || p2_valid) begin
			$display("Timeout, %0d port 1 and %0d port 2 writes never came out",
				exp_p1_q.size(), exp_p2_q.size());
			aborted = 1;
		end
		@(posedge CLK_48M);
	endtask

	task automatic run_test();
		int          k;
		int          r;
		int          o;
		int          gap;
		int          err_start;
		logic [26:0] dl;
		logic [7:0]  hb;
		tests++;
		err_start = errors;
		n_p1 = 0;
		n_p2 = 0;
		// Expected writes per port in file order
		dl = 27'(HDR_LEN);
		for (r = 0; r < 6; r++) begin
			for (o = 0; o < sz[r]; o++) begin
				rom_q.push_back(8'($random(seed)));
				if (r < 3)
					exp_p1_q.push_back(p1_expect(r, o, rom_q[$]));
				else
					exp_p2_q.push_back(p2_expect(r, o, dl, rom_q[$]));
				dl++;
			end
		end
		for (k = 0; k < HDR_LEN; k++) begin
			hb = 8'h00;
			if (k >= 4 && k < 28)
				hb = 8'(sz[(k - 4) / 4] >> (8 * ((k - 4) % 4)));
			send_byte(27'(k), hb);
		end
		dl_valid <= 1'b0;
		@(negedge CLK_48M);
		if (load_done !== 1'b0)
			report_mismatch("load_done", 0, load_done);
		@(posedge CLK_48M);
		dl = 27'(HDR_LEN);
		for (k = 0; k < rom_q.size(); k++) begin
			gap = {$random(seed)} % 3;
			if (gap != 0) begin
				dl_valid <= 1'b0;
				repeat (gap) @(posedge CLK_48M);
			end
			send_byte(dl, rom_q[k]);
			dl++;
		end
		dl_valid <= 1'b0;
		wait_load_done();
		// Trailing bytes past the file are dropped
		for (k = 0; k < 3; k++)
			send_byte(dl + 27'(k), 8'($random(seed)));
		dl_valid <= 1'b0;
		wait_drain();
		@(negedge CLK_48M);
		if (load_done !== 1'b1)
			report_mismatch("load_done", 1, load_done);
		if (n_p1 != exp_n1)
			report_mismatch("p1 write count", exp_n1, n_p1);
		if (n_p2 != exp_n2)
			report_mismatch("p2 write count", exp_n2, n_p2);
		@(posedge CLK_48M);
		rom_q.delete();
		exp_p1_q.delete();
		exp_p2_q.delete();
		$display("Test %0d: %0d port 1 writes, %0d port 2 writes, %0d errors",
			tests, n_p1, n_p2, errors - err_start);
	endtask

	initial begin
		int    fd;
		int    n;
		string line;
		CLK_48M   = 1'b0;
		rst       = 1'b1;
		dl_byte   = '0;
		dl_valid  = 1'b0;
		p1_ready  = 1'b0;
		p2_ready  = 1'b0;
		seed      = 99209;
		rdy_seed  = seed + 1;
		ready_pct = 100;
		errors    = 0;
		tests     = 0;
		aborted   = 0;
		fd = $fopen("verif/cart_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open verif/cart_input.txt");
			aborted = 1;
		end
		repeat (16) @(posedge CLK_48M);
		rst <= 1'b0;
		while (fd != 0 && !aborted && !$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			n = $sscanf(line, "%d %d %d %d %d %d %d %d %d", sz[0], sz[1], sz[2], sz[3],
				sz[4], sz[5], ready_pct, exp_n1, exp_n2);
			if (n == 9)
				run_test();
		end
		if (fd != 0)
			$fclose(fd);
		$display("Tests run %0d, errors %0d, assertion failures %0d", tests, errors,
			u_dut.u_chk.fails);
		if (errors == 0 && u_dut.u_chk.fails == 0 && !aborted && tests > 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/cart_input.txt
# p_size s_size m_size v1_size v2_size c_size ready_pct p1_writes p2_writes
# sizes in bytes, ready_pct is the percent chance that each ready is high in a cycle
40 20 16 24 12 64 100 76 100
33 0 10 17 0 50 60 43 67
20 8 5 9 7 130 30 33 146
0 12 0 5 0 0 50 12 5
64 32 0 0 0 200 75 96 200

// File: sim.f
source/neo_pkg.sv
source/neo_header_parser.sv
source/neo_region_ctrl.sv
source/neo_addr_map.sv
source/neo_write_port.sv
source/neo_cart_loader.sv
verif/neo_cart_loader_chk.sv
verif/tb_neo_cart_loader.sv

// File: Bender.yml
package:
  name: neo_cart_loader

sources:
  - source/neo_pkg.sv
  - source/neo_header_parser.sv
  - source/neo_region_ctrl.sv
  - source/neo_addr_map.sv
  - source/neo_write_port.sv
  - source/neo_cart_loader.sv
  - target: test
    files:
      - verif/neo_cart_loader_chk.sv
      - verif/tb_neo_cart_loader.sv
